// File: design/dac_pkg.sv
// shared constants and types for the nanoDAC controller
// the AD5601 word holds mode in [15:14], data in [13:6] and reserved bits in [5:0]

package dac_pkg;

    //////////////////////////////
    // register map word offsets
    localparam logic [1:0] ADDR_MODULE_ID      = 2'd0;
    localparam logic [1:0] ADDR_MODULE_VERSION = 2'd1;
    localparam logic [1:0] ADDR_DAC_REG        = 2'd2;
    localparam logic [1:0] ADDR_EN_MMI_CTRL    = 2'd3;
    localparam int         NUM_REGS            = 4;

    localparam logic [15:0] MODULE_VERSION = 16'd1;

    //////////////////////////////
    // frame and field layout
    localparam int DAC_FRAME_LEN = 16;
    localparam int GAIN_WIDTH    = 8;
    localparam int GAIN_LSB      = 6;

    typedef logic [DAC_FRAME_LEN-1:0] dac_word_t;
    typedef logic [GAIN_WIDTH-1:0]    gain_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_start_default,
        seq_busy
    } seq_state_t;

endpackage

// File: design/spi_cmd_if.sv
// command path between the update sequencer and the SPI shifter
// tx_word must stay stable from start until done

`timescale 1ns/1ps

interface spi_cmd_if import dac_pkg::*; ();

    logic      start;
    dac_word_t tx_word;
    logic      busy;
    logic      done;

    // sequencer side
    modport master (output start, output tx_word, input busy, input done);

    // serializer side
    modport shifter (input start, input tx_word, output busy, output done);

endinterface

// File: design/dac_apb_regs.sv
// APB slave with no wait states; only the low 16 data bits are meaningful
// DAC_REG writes are dropped while en_mmi_ctrl is low

`timescale 1ns/1ps

module dac_apb_regs import dac_pkg::*; #(
    parameter logic [15:0] MODULE_ID   = 16'h0000,
    parameter logic [15:0] DAC_DEFAULT = 16'h0000
) (
    input  logic        clk_ifc,
    input  logic        set_default_on_reset,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        en_mmi_ctrl,
    input  logic        word_load,
    input  dac_word_t   load_word,
    output logic        mmi_write,
    output dac_word_t   mmi_word,
    output dac_word_t   dac_word
);

    logic [1:0] reg_idx;
    logic       wr_access;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    // word index from the byte address
    assign reg_idx   = paddr[3:2];
    assign wr_access = psel && penable && pwrite;

    assign mmi_write = wr_access && (reg_idx == ADDR_DAC_REG) && en_mmi_ctrl;
    assign mmi_word  = pwdata[DAC_FRAME_LEN-1:0];

    //////////////////////////////
    // stored DAC word
    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            dac_word <= DAC_DEFAULT;
        end else if (mmi_write) begin
            dac_word <= mmi_word;
        end else if (word_load) begin
            // gain frame built by the sequencer
            dac_word <= load_word;
        end
    end

    //////////////////////////////
    // read mux
    always_comb begin
        prdata = '0;
        if (psel && !pwrite && (int'(reg_idx) < NUM_REGS)) begin
            case (reg_idx)
                ADDR_MODULE_ID:      prdata[15:0] = MODULE_ID;
                ADDR_MODULE_VERSION: prdata[15:0] = MODULE_VERSION;
                ADDR_DAC_REG:        prdata[DAC_FRAME_LEN-1:0] = dac_word;
                ADDR_EN_MMI_CTRL:    prdata[0] = en_mmi_ctrl;
                default:             prdata = '0;
            endcase
        end
    end

endmodule

// File: design/dac_gain_capture.sv
// holds one gain sample; a newer strobe replaces an unsent one
// strobes are ignored while en_mmi_ctrl is high

`timescale 1ns/1ps

module dac_gain_capture import dac_pkg::*; (
    input  logic  clk_ifc,
    input  logic  set_default_on_reset,
    input  gain_t gain,
    input  logic  gain_valid,
    input  logic  en_mmi_ctrl,
    input  logic  gain_take,
    input  logic  frame_done,
    output logic  gain_pending,
    output gain_t held_gain,
    output logic  gain_updated
);

    logic gain_in_flight;

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            gain_pending   <= 1'b0;
            gain_in_flight <= 1'b0;
        end else begin
            // a fresh strobe wins over a take in the same cycle
            if (gain_valid && !en_mmi_ctrl) begin
                gain_pending <= 1'b1;
            end else if (gain_take) begin
                gain_pending <= 1'b0;
            end
            if (gain_take) begin
                gain_in_flight <= 1'b1;
            end else if (frame_done) begin
                gain_in_flight <= 1'b0;
            end
        end
    end

    // sample payload
    always_ff @(posedge clk_ifc) begin
        if (gain_valid && !en_mmi_ctrl) begin
            held_gain <= gain;
        end
    end

    assign gain_updated = frame_done && gain_in_flight;

endmodule

// File: design/dac_update_sequencer.sv
// picks the next DAC word; APB requests beat gain requests when both wait
// only the newest word of each source is kept while a frame runs

`timescale 1ns/1ps

module dac_update_sequencer import dac_pkg::*; #(
    parameter bit LOAD_DEFAULT_AT_START = 1'b1
) (
    input  logic      clk_ifc,
    input  logic      set_default_on_reset,
    input  logic      mmi_write,
    input  dac_word_t mmi_word,
    input  dac_word_t dac_word,
    input  logic      gain_pending,
    input  gain_t     held_gain,
    output logic      word_load,
    output dac_word_t load_word,
    output logic      gain_take,
    output logic      frame_done,
    output logic      initdone,
    spi_cmd_if.master cmd
);

    seq_state_t state;
    logic       apb_pending;
    dac_word_t  apb_word;
    logic       idle_ready;
    logic       take_apb;

    // stored word with the gain field replaced
    always_comb begin
        load_word = dac_word;
        load_word[GAIN_LSB +: GAIN_WIDTH] = held_gain;
    end

    assign idle_ready = (state == seq_idle) && !cmd.busy;
    assign take_apb   = idle_ready && (mmi_write || apb_pending);
    assign gain_take  = idle_ready && !take_apb && gain_pending;
    assign word_load  = gain_take;
    assign frame_done = cmd.done;

    //////////////////////////////
    // frame ordering FSM
    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state       <= LOAD_DEFAULT_AT_START ? seq_start_default : seq_idle;
            apb_pending <= 1'b0;
            cmd.start   <= 1'b0;
            initdone    <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            if (!LOAD_DEFAULT_AT_START || cmd.done) begin
                initdone <= 1'b1;
            end
            // record writes that cannot go out right now
            if (mmi_write && !take_apb) begin
                apb_pending <= 1'b1;
            end
            case (state)
                seq_start_default: begin
                    if (!cmd.busy) begin
                        cmd.start <= 1'b1;
                        state     <= seq_busy;
                    end
                end
                seq_idle: begin
                    if (take_apb) begin
                        apb_pending <= 1'b0;
                        cmd.start   <= 1'b1;
                        state       <= seq_busy;
                    end else if (gain_take) begin
                        cmd.start <= 1'b1;
                        state     <= seq_busy;
                    end
                end
                default: begin
                    if (cmd.done) begin
                        state <= seq_idle;
                    end
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk_ifc) begin
        if (mmi_write && !take_apb) begin
            apb_word <= mmi_word;
        end
        if (state == seq_start_default && !cmd.busy) begin
            cmd.tx_word <= dac_word;
        end else if (take_apb) begin
            cmd.tx_word <= mmi_write ? mmi_word : apb_word;
        end else if (gain_take) begin
            cmd.tx_word <= load_word;
        end
    end

endmodule

// File: design/dac_spi_shifter.sv
// SPI master sending one 16-bit frame MSB first with sclk idling high
// sdin moves on the rising sclk edge; the DAC samples on the falling edge

`timescale 1ns/1ps

module dac_spi_shifter import dac_pkg::*; #(
    parameter int SCLK_DIV = 2
) (
    input  logic       clk_ifc,
    input  logic       set_default_on_reset,
    spi_cmd_if.shifter cmd,
    output logic       sclk,
    output logic       sync_n,
    output logic       sdin
);

    localparam int CNT_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(DAC_FRAME_LEN);

    logic [CNT_W-1:0] half_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             half_end;
    dac_word_t        shreg;

    assign half_end = (half_cnt == CNT_W'(SCLK_DIV - 1));

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            cmd.busy <= 1'b0;
            cmd.done <= 1'b0;
            sclk     <= 1'b1;
            sync_n   <= 1'b1;
            sdin     <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            cmd.done <= 1'b0;
            if (!cmd.busy) begin
                if (cmd.start) begin
                    // first bit goes out together with sync_n
                    cmd.busy <= 1'b1;
                    sync_n   <= 1'b0;
                    sdin     <= cmd.tx_word[DAC_FRAME_LEN-1];
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (!half_end) begin
                half_cnt <= half_cnt + 1'b1;
            end else begin
                half_cnt <= '0;
                sclk     <= !sclk;
                if (!sclk) begin
                    // rising edge ends one bit period
                    if (bit_cnt == BIT_W'(DAC_FRAME_LEN - 1)) begin
                        cmd.busy <= 1'b0;
                        cmd.done <= 1'b1;
                        sync_n   <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        sdin    <= shreg[DAC_FRAME_LEN-2];
                    end
                end
            end
        end
    end

    // shift register payload
    always_ff @(posedge clk_ifc) begin
        if (!cmd.busy && cmd.start) begin
            shreg <= cmd.tx_word;
        end else if (cmd.busy && half_end && !sclk) begin
            shreg <= shreg << 1;
        end
    end

endmodule

// File: design/dac_ctrl_top.sv
// nanoDAC controller top level; one synchronous reset serves all blocks
// SCLK_DIV sets system clocks per sclk half period and must be at least 1

`timescale 1ns/1ps

module dac_ctrl_top import dac_pkg::*; #(
    parameter logic [15:0] MODULE_ID             = 16'h0000,
    parameter logic [15:0] DAC_DEFAULT           = 16'h0000,
    parameter bit          LOAD_DEFAULT_AT_START = 1'b1,
    parameter int          SCLK_DIV              = 2
) (
    input  logic        clk_ifc,
    input  logic        set_default_on_reset,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        en_mmi_ctrl,
    input  gain_t       gain,
    input  logic        gain_valid,
    output logic        gain_updated,
    output logic        initdone,
    output logic        sclk,
    output logic        sync_n,
    output logic        sdin
);

    logic      mmi_write;
    dac_word_t mmi_word;
    dac_word_t dac_word;
    logic      word_load;
    dac_word_t load_word;
    logic      gain_pending;
    gain_t     held_gain;
    logic      gain_take;
    logic      frame_done;

    spi_cmd_if cmd ();

    dac_apb_regs #(
        .MODULE_ID   (MODULE_ID),
        .DAC_DEFAULT (DAC_DEFAULT)
    ) i_dac_apb_regs (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .paddr                (paddr),
        .psel                 (psel),
        .penable              (penable),
        .pwrite               (pwrite),
        .pwdata               (pwdata),
        .prdata               (prdata),
        .pready               (pready),
        .pslverr              (pslverr),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .word_load            (word_load),
        .load_word            (load_word),
        .mmi_write            (mmi_write),
        .mmi_word             (mmi_word),
        .dac_word             (dac_word)
    );

    dac_gain_capture i_dac_gain_capture (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .gain                 (gain),
        .gain_valid           (gain_valid),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .gain_take            (gain_take),
        .frame_done           (frame_done),
        .gain_pending         (gain_pending),
        .held_gain            (held_gain),
        .gain_updated         (gain_updated)
    );

    dac_update_sequencer #(
        .LOAD_DEFAULT_AT_START (LOAD_DEFAULT_AT_START)
    ) i_dac_update_sequencer (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .mmi_write            (mmi_write),
        .mmi_word             (mmi_word),
        .dac_word             (dac_word),
        .gain_pending         (gain_pending),
        .held_gain            (held_gain),
        .word_load            (word_load),
        .load_word            (load_word),
        .gain_take            (gain_take),
        .frame_done           (frame_done),
        .initdone             (initdone),
        .cmd                  (cmd.master)
    );

    dac_spi_shifter #(
        .SCLK_DIV (SCLK_DIV)
    ) i_dac_spi_shifter (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .cmd                  (cmd.shifter),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

endmodule

// File: tests/tb_dac_ctrl.sv
// self-checking testbench for the nanoDAC controller with a fixed LFSR seed
// frames are rebuilt from the SPI pins, so SCLK_DIV only changes the run length

`timescale 1ns/1ps

module tb_dac_ctrl import dac_pkg::*; ();

    localparam int          SCLK_DIV              = 2;
    localparam bit          LOAD_DEFAULT_AT_START = 1'b1;
    localparam logic [15:0] MODULE_ID             = 16'h5A01;
    localparam logic [15:0] DAC_DEFAULT           = 16'h8040;

    localparam int CLK_HALF  = 4;
    localparam int DRIVE_DLY = 1;
    localparam int N_WR      = 10;
    localparam int N_OFF     = 4;
    localparam int N_GAIN    = 10;
    localparam int N_BURST   = 3;
    localparam int IDLE_CYC  = 8;

    // one default frame plus one per single update, two per burst and three for the mixed case
    localparam int NUM_FRAMES  = 1 + N_WR + N_GAIN + 4 * N_BURST + 3;
    localparam int FRAME_CYC   = DAC_FRAME_LEN * 2 * SCLK_DIV;
    localparam int CYCLE_LIMIT = NUM_FRAMES * (FRAME_CYC + 64) + 1000;

    logic        clk_ifc;
    logic        set_default_on_reset;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        en_mmi_ctrl;
    gain_t       gain;
    logic        gain_valid;
    logic        gain_updated;
    logic        initdone;
    logic        sclk;
    logic        sync_n;
    logic        sdin;

    logic [15:0] lfsr_state;
    dac_word_t   rx_q[$];
    dac_word_t   exp_q[$];
    dac_word_t   stored;
    dac_word_t   mon_word;
    int          mon_bits  = 0;
    int          upd_cnt   = 0;
    int          exp_upd   = 0;
    int          cycle_cnt = 0;

    dac_ctrl_top #(
        .MODULE_ID             (MODULE_ID),
        .DAC_DEFAULT           (DAC_DEFAULT),
        .LOAD_DEFAULT_AT_START (LOAD_DEFAULT_AT_START),
        .SCLK_DIV              (SCLK_DIV)
    ) i_dac_ctrl_top (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .paddr                (paddr),
        .psel                 (psel),
        .penable              (penable),
        .pwrite               (pwrite),
        .pwdata               (pwdata),
        .prdata               (prdata),
        .pready               (pready),
        .pslverr              (pslverr),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .gain                 (gain),
        .gain_valid           (gain_valid),
        .gain_updated         (gain_updated),
        .initdone             (initdone),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #CLK_HALF clk_ifc = ~clk_ifc;
    end

    always @(posedge clk_ifc) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Test failures found");
            $fatal(1, "timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        end
    end

    //////////////////////////////
    // monitors

    // DAC side view with data taken on falling sclk while sync_n is low
    always @(negedge sclk) begin
        if (sync_n === 1'b0) begin
            mon_word = {mon_word[DAC_FRAME_LEN-2:0], sdin};
            mon_bits++;
            if (mon_bits == DAC_FRAME_LEN) begin
                rx_q.push_back(mon_word);
                mon_bits = 0;
            end
        end
    end

    // a frame cut short leaves bits behind
    always @(posedge sync_n) begin
        check_eq(32'(mon_bits), 32'd0, "sync_n rose in the middle of a frame");
    end

    always @(negedge clk_ifc) begin
        if (gain_updated === 1'b1) begin
            upd_cnt++;
        end
    end

    //////////////////////////////
    // helpers

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    // mode [15:14] and reserved [5:0] survive and gain lands in [13:6]
    function automatic dac_word_t merge_gain(input dac_word_t word, input gain_t g);
        return {word[15:14], g, word[5:0]};
    endfunction

    task automatic drive_edge();
        @(posedge clk_ifc);
        #DRIVE_DLY;
    endtask

    task automatic apb_xfer(input logic wr, input logic [1:0] idx, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        drive_edge();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = {idx, 2'b00};
        pwdata  = wdata;
        drive_edge();
        penable = 1'b1;
        @(negedge clk_ifc);
        rdata = prdata;
        check_eq(32'(pready), 32'd1, "pready low in the access phase");
        check_eq(32'(pslverr), 32'd0, "pslverr set");
        drive_edge();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [1:0] idx, input logic [31:0] data);
        logic [31:0] ignored;
        apb_xfer(1'b1, idx, data, ignored);
    endtask

    task automatic apb_read_check(input logic [1:0] idx, input logic [31:0] exp,
                                  input string what);
        logic [31:0] rdata;
        apb_xfer(1'b0, idx, 32'd0, rdata);
        check_eq(rdata, exp, what);
    endtask

    task automatic gain_strobe(input gain_t g);
        drive_edge();
        gain       = g;
        gain_valid = 1'b1;
        drive_edge();
        gain_valid = 1'b0;
    endtask

    task automatic set_enable(input logic v);
        drive_edge();
        en_mmi_ctrl = v;
    endtask

    task automatic wait_frame_start();
        while (sync_n !== 1'b0) begin
            @(negedge clk_ifc);
        end
    endtask

    // wait for the expected frames, make sure nothing else follows, then compare
    task automatic settle_and_compare(input string what);
        while (rx_q.size() < exp_q.size() || sync_n !== 1'b1) begin
            @(negedge clk_ifc);
        end
        repeat (IDLE_CYC) @(negedge clk_ifc);
        check_eq(32'(sync_n), 32'd1, {what, ": unexpected frame started"});
        check_eq(32'(rx_q.size()), 32'(exp_q.size()), {what, ": frame count"});
        while (exp_q.size() > 0) begin
            check_eq(32'(rx_q.pop_front()), 32'(exp_q.pop_front()), {what, ": frame word"});
        end
        check_eq(32'(upd_cnt), 32'(exp_upd), {what, ": gain_updated pulses"});
    endtask

    //////////////////////////////
    // test sequence
    initial begin
        logic [31:0] rnd;
        gain_t       g;
        int          burst_len;
        int          waited;

        lfsr_state           = 16'd58295;
        set_default_on_reset = 1'b1;
        paddr                = '0;
        psel                 = 1'b0;
        penable              = 1'b0;
        pwrite               = 1'b0;
        pwdata               = '0;
        en_mmi_ctrl          = 1'b1;
        gain                 = '0;
        gain_valid           = 1'b0;
        mon_word             = '0;
        stored               = DAC_DEFAULT;

        repeat (4) @(posedge clk_ifc);
        #DRIVE_DLY;
        set_default_on_reset = 1'b0;

        // initdone stays low until the default frame has ended
        while (rx_q.size() == 0 || sync_n !== 1'b1) begin
            @(negedge clk_ifc);
            check_eq(32'(initdone), 32'd0, "initdone before the default frame ended");
        end
        waited = 0;
        while (initdone !== 1'b1 && waited < 4) begin
            @(negedge clk_ifc);
            waited++;
        end
        check_eq(32'(initdone), 32'd1, "initdone after the default frame");
        exp_q.push_back(DAC_DEFAULT);
        settle_and_compare("default frame");

        // paddr[3:2] reaches only the NUM_REGS defined words
        apb_read_check(ADDR_MODULE_ID, 32'(MODULE_ID), "MODULE_ID read");
        apb_read_check(ADDR_MODULE_VERSION, 32'd1, "MODULE_VERSION read");
        apb_read_check(ADDR_DAC_REG, 32'(DAC_DEFAULT), "DAC_REG after reset");
        apb_read_check(ADDR_EN_MMI_CTRL, 32'd1, "EN_MMI_CTRL high");

        for (int i = 0; i < N_WR; i++) begin
            rnd = next_bits(32);
            apb_write(ADDR_DAC_REG, rnd);
            stored = rnd[15:0];
            exp_q.push_back(stored);
            settle_and_compare("APB write");
            apb_read_check(ADDR_DAC_REG, 32'(stored), "DAC_REG readback");
        end

        set_enable(1'b0);
        apb_read_check(ADDR_EN_MMI_CTRL, 32'd0, "EN_MMI_CTRL low");
        for (int i = 0; i < N_OFF; i++) begin
            rnd = next_bits(32);
            apb_write(ADDR_DAC_REG, rnd);
            settle_and_compare("write while disabled");
            apb_read_check(ADDR_DAC_REG, 32'(stored), "DAC_REG after ignored write");
        end

        // gain strobes are dropped under MMI control
        set_enable(1'b1);
        rnd = next_bits(GAIN_WIDTH);
        gain_strobe(rnd[7:0]);
        settle_and_compare("gain while enabled");

        set_enable(1'b0);
        for (int i = 0; i < N_GAIN; i++) begin
            rnd = next_bits(GAIN_WIDTH);
            gain_strobe(rnd[7:0]);
            stored = merge_gain(stored, rnd[7:0]);
            exp_q.push_back(stored);
            exp_upd++;
            settle_and_compare("gain update");
            apb_read_check(ADDR_DAC_REG, 32'(stored), "DAC_REG after gain");
        end

        // bursts during a running frame coalesce into one more frame
        for (int b = 0; b < N_BURST; b++) begin
            set_enable(1'b1);
            rnd = next_bits(32);
            apb_write(ADDR_DAC_REG, rnd);
            exp_q.push_back(rnd[15:0]);
            wait_frame_start();
            rnd = next_bits(3);
            burst_len = 2 + int'(rnd[2:0]);
            for (int k = 0; k < burst_len; k++) begin
                rnd = next_bits(32);
                apb_write(ADDR_DAC_REG, rnd);
            end
            stored = rnd[15:0];
            exp_q.push_back(stored);
            settle_and_compare("APB burst");
            apb_read_check(ADDR_DAC_REG, 32'(stored), "DAC_REG after APB burst");

            set_enable(1'b0);
            rnd = next_bits(GAIN_WIDTH);
            gain_strobe(rnd[7:0]);
            stored = merge_gain(stored, rnd[7:0]);
            exp_q.push_back(stored);
            wait_frame_start();
            rnd = next_bits(3);
            burst_len = 2 + int'(rnd[2:0]);
            for (int k = 0; k < burst_len; k++) begin
                rnd = next_bits(GAIN_WIDTH);
                gain_strobe(rnd[7:0]);
            end
            stored = merge_gain(stored, rnd[7:0]);
            exp_q.push_back(stored);
            exp_upd += 2;
            settle_and_compare("gain burst");
            apb_read_check(ADDR_DAC_REG, 32'(stored), "DAC_REG after gain burst");
        end

        // both sources pending after a mid-frame toggle and APB goes first
        rnd = next_bits(GAIN_WIDTH);
        gain_strobe(rnd[7:0]);
        stored = merge_gain(stored, rnd[7:0]);
        exp_q.push_back(stored);
        wait_frame_start();
        rnd = next_bits(GAIN_WIDTH);
        g = rnd[7:0];
        gain_strobe(g);
        set_enable(1'b1);
        rnd = next_bits(32);
        apb_write(ADDR_DAC_REG, rnd);
        stored = rnd[15:0];
        exp_q.push_back(stored);
        stored = merge_gain(stored, g);
        exp_q.push_back(stored);
        exp_upd += 2;
        settle_and_compare("mixed sources");
        apb_read_check(ADDR_DAC_REG, 32'(stored), "DAC_REG after mixed sources");

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: build.f
design/dac_pkg.sv
design/spi_cmd_if.sv
design/dac_apb_regs.sv
design/dac_gain_capture.sv
design/dac_update_sequencer.sv
design/dac_spi_shifter.sv
design/dac_ctrl_top.sv
tests/tb_dac_ctrl.sv

// File: Makefile
# Verilator build and run for the nanoDAC controller testbench
# the run target fails when the testbench stops with $fatal

VERILATOR ?= verilator
TOP       ?= tb_dac_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
BIN       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
